/* files.f */
logic/sifhPkg.sv
logic/timestampBinner.sv
logic/binCounter.sv
logic/peakDetector.sv
logic/histController.sv
logic/sifhTop.sv
testbench/sifhTop_checker.sv
testbench/sifhTb.sv

/* Bender.yml */
package:
  name: sifh

sources:
  - target: rtl
    files:
      - logic/sifhPkg.sv
      - logic/timestampBinner.sv
      - logic/binCounter.sv
      - logic/peakDetector.sv
      - logic/histController.sv
      - logic/sifhTop.sv
  - target: test
    files:
      - testbench/sifhTop_checker.sv
      - testbench/sifhTb.sv

/* testbench/sifhTb.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhTb;

    localparam int CLK_PERIOD = 20;
    localparam int SAMPLES = 32;
    localparam int NUM_TESTS = 9;
    // two passes of 32 strobes plus scan and report per test
    localparam longint TEST_NS = NUM_TESTS * (64 + 40) * CLK_PERIOD;
    localparam longint WATCHDOG_NS = TEST_NS + TEST_NS / 2 + 100 * CLK_PERIOD;

    logic                       clk;
    logic                       rstN;
    logic                       wrEn;
    logic [sifhPkg::TIME_W-1:0] roughData;
    logic                       busy;
    logic                       resultValid;
    sifhPkg::sifhResult         result;

    logic [31:0] seed;
    int          errors;
    int          checks;

    // reference model state
    int                         mCount [16];
    int                         mSamples;
    bit                         mFine;
    logic [sifhPkg::BIN_W-1:0]  mCoarse;
    logic [sifhPkg::TIME_W-1:0] mBase;
    sifhPkg::sifhResult         expQ [$];
    sifhPkg::sifhResult         expResult;

    sifhTop u_dut (
        .clk         (clk),
        .rstN        (rstN),
        .wrEn        (wrEn),
        .roughData   (roughData),
        .busy        (busy),
        .resultValid (resultValid),
        .result      (result)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        seed = xorshift(seed);
        return seed;
    endfunction

    // argmax over the model bins with the lowest bin winning a tie
    function automatic logic [sifhPkg::BIN_W-1:0] lowestPeak();
        int best;
        logic [sifhPkg::BIN_W-1:0] bin;
        best = -1;
        bin = '0;
        for (int b = 0; b < 16; b++) begin
            if (mCount[b] > best) begin
                best = mCount[b];
                bin = b[3:0];
            end
        end
        return bin;
    endfunction

    // bin one accepted strobe and close the pass after 32
    task automatic modelAccept(input logic [sifhPkg::TIME_W-1:0] ts);
        logic [sifhPkg::TIME_W-1:0] offset;
        logic [sifhPkg::BIN_W-1:0]  fine;
        sifhPkg::sifhResult         r;
        offset = ts - mBase;
        if (!mFine) begin
            // 64 units per coarse bin
            mCount[ts / 64]++;
        end else if (offset < 64) begin
            // 4 units per fine bin and the rest of the range dropped
            mCount[offset / 4]++;
        end
        mSamples++;
        if (mSamples == SAMPLES) begin
            mSamples = 0;
            if (!mFine) begin
                mCoarse = lowestPeak();
                mBase = 10'(mCoarse) * 10'd64;
                mFine = 1'b1;
            end else begin
                fine = lowestPeak();
                r.coarsePeak = mCoarse;
                r.finePeak = fine;
                r.peakTime = mBase + 10'(fine) * 10'd4;
                expQ.push_back(r);
                mFine = 1'b0;
                mBase = '0;
            end
            foreach (mCount[b]) mCount[b] = 0;
        end
    endtask

    // one strobe with an occasional idle gap before it
    task automatic sendStrobe(input logic [sifhPkg::TIME_W-1:0] ts, output bit taken);
        if (nextRand() % 8 == 0) begin
            @(negedge clk);
            wrEn = 1'b0;
        end
        @(negedge clk);
        wrEn = 1'b1;
        roughData = ts;
        // busy only moves on the rising edge
        taken = !busy;
        if (taken) modelAccept(ts);
    endtask

    // one repeated junk timestamp while busy so a leak piles into a single bin
    task automatic drainBusy(input logic [sifhPkg::TIME_W-1:0] junk);
        do begin
            @(negedge clk);
            wrEn = busy;
            roughData = junk;
        end while (busy);
    endtask

    // mode selects clustered (0), out-of-window noise (1) or tie (2) stimulus
    task automatic runTest(input int mode, input logic [sifhPkg::TIME_W-1:0] centre);
        int i;
        bit ok;
        logic [sifhPkg::TIME_W-1:0] ts;
        logic [sifhPkg::TIME_W-1:0] fc;
        logic [sifhPkg::TIME_W-1:0] fineTop;
        i = 0;
        while (i < SAMPLES) begin
            if (mode == 2) ts = {(i % 2 == 0) ? 4'd5 : 4'd3, 6'(nextRand())};
            else ts = centre + 10'(nextRand() % 33) - 10'd16;
            sendStrobe(ts, ok);
            if (ok) i++;
        end
        // coarse bin 15 is the last one the scan reads
        drainBusy(10'h3ff);
        // fine target kept inside the window
        fc = mBase + 10'(8 + nextRand() % 48);
        // top unit of the window lands in the last scanned fine bin
        fineTop = mBase + 10'd63;
        i = 0;
        while (i < SAMPLES) begin
            if (mode == 2) begin
                ts = mBase + ((i % 2 == 0) ? 10'd36 : 10'd8) + 10'(nextRand() % 4);
            end else if (mode == 1) begin
                // noise packed into one 4-unit bin half the range away
                if (i % 8 < 5) ts = (mBase ^ 10'h200) + 10'(nextRand() % 4);
                else ts = fc + 10'(nextRand() % 5) - 10'd2;
            end else begin
                if (nextRand() % 4 == 0) ts = 10'(nextRand());
                else ts = fc + 10'(nextRand() % 9) - 10'd4;
            end
            sendStrobe(ts, ok);
            if (ok) i++;
        end
        drainBusy(fineTop);
    endtask

    // result check sampled mid-cycle
    always @(negedge clk) begin
        if (rstN && resultValid) begin
            checks++;
            assert (expQ.size() > 0) else begin
                errors++;
                $display("result pulse at %0t with no finished pass in the model", $time);
            end
            if (expQ.size() > 0) begin
                expResult = expQ.pop_front();
                assert (result == expResult) else begin
                    errors++;
                    $display("MISMATCH at %0t: coarse %0d fine %0d time %0d, expected %0d %0d %0d",
                        $time, result.coarsePeak, result.finePeak, result.peakTime,
                        expResult.coarsePeak, expResult.finePeak, expResult.peakTime);
                end
            end
        end
    end

    initial begin
        seed = 32'hc0d8d959;
        errors = 0;
        checks = 0;
        mSamples = 0;
        mFine = 1'b0;
        mCoarse = '0;
        mBase = '0;
        foreach (mCount[b]) mCount[b] = 0;
        rstN = 1'b0;
        wrEn = 1'b0;
        roughData = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        // quiet after reset
        repeat (30) begin
            @(negedge clk);
            checks++;
            assert (!busy && !resultValid) else begin
                errors++;
                $display("MISMATCH at %0t: busy or resultValid high with no strobes", $time);
            end
        end
        for (int t = 0; t < 6; t++) runTest(0, 10'(nextRand()));
        runTest(1, 10'(nextRand()));
        runTest(1, 10'(nextRand()));
        runTest(2, '0);
        repeat (4) @(negedge clk);
        checks++;
        assert (expQ.size() == 0) else begin
            errors++;
            $display("%0d predicted results were never reported", expQ.size());
        end
        errors += u_dut.u_checker.failCount;
        $display("checks: %0d  errors: %0d  assertion failures: %0d",
            checks, errors, u_dut.u_checker.failCount);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/sifhTop_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhTopChecker (
    input wire logic               clk,
    input wire logic               rstN,
    input wire logic               busy,
    input wire logic               resultValid,
    input wire sifhPkg::sifhResult result,
    input wire sifhPkg::sifhWindow window
);

    int failCount = 0;

    // result pulse is one cycle wide
    resultPulse: assert property (@(posedge clk) disable iff (!rstN)
        resultValid |=> !resultValid)
        else begin failCount++; $error("resultValid high for more than one cycle"); end

    // result only moves together with the pulse
    resultHeld: assert property (@(posedge clk) disable iff (!rstN)
        !resultValid |-> $stable(result))
        else begin failCount++; $error("result changed between pulses"); end

    // busy rises on the last fine strobe, report 20 cycles later
    fineLatency: assert property (@(posedge clk) disable iff (!rstN)
        $rose(busy) && window.phase == sifhPkg::FINE |-> ##19 resultValid ##1 !resultValid)
        else begin failCount++; $error("resultValid not 20 cycles after last fine strobe"); end

    // outputs quiet in reset
    resetQuiet: assert property (@(posedge clk)
        !rstN |-> !busy && !resultValid)
        else begin failCount++; $error("busy or resultValid high during reset"); end

endmodule

bind sifhTop sifhTopChecker u_checker (
    .clk         (clk),
    .rstN        (rstN),
    .busy        (busy),
    .resultValid (resultValid),
    .result      (result),
    .window      (window)
);

`default_nettype wire

/* logic/sifhTop.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhTop (
    input  wire logic                        clk,
    input  wire logic                        rstN,
    input  wire logic                        wrEn,
    input  wire logic [sifhPkg::TIME_W-1:0]  roughData,
    output logic                             busy,
    output logic                             resultValid,
    output sifhPkg::sifhResult               result
);

    logic                              accept;
    logic                              clearBins;
    logic                              scanStart;
    logic                              peakDone;
    logic [sifhPkg::BIN_W-1:0]         peakBin;
    sifhPkg::sifhWindow                window;
    sifhPkg::binHit                    hit;
    sifhPkg::binCountArray             counts;

    // timestamp to one-hot bin
    timestampBinner u_binner (
        .clk       (clk),
        .rstN      (rstN),
        .accept    (accept),
        .roughData (roughData),
        .window    (window),
        .hit       (hit)
    );

    // one counter per histogram bin
    for (genvar i = 0; i < sifhPkg::NUM_BINS; i++) begin : g_bin
        binCounter u_bin (
            .clk   (clk),
            .rstN  (rstN),
            .clear (clearBins),
            .inc   (hit.valid & hit.vec[i]),
            .count (counts[i])
        );
    end

    // argmax over the counters
    peakDetector u_peak (
        .clk      (clk),
        .rstN     (rstN),
        .start    (scanStart),
        .counts   (counts),
        .peakDone (peakDone),
        .peakBin  (peakBin)
    );

    // pass sequencing, window and result
    histController u_ctrl (
        .clk         (clk),
        .rstN        (rstN),
        .wrEn        (wrEn),
        .peakDone    (peakDone),
        .peakBin     (peakBin),
        .accept      (accept),
        .window      (window),
        .clearBins   (clearBins),
        .scanStart   (scanStart),
        .busy        (busy),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

`default_nettype wire

/* logic/histController.sv */
`timescale 1ns/1ps
`default_nettype none

module histController (
    input  wire logic                        clk,
    input  wire logic                        rstN,
    input  wire logic                        wrEn,
    input  wire logic                        peakDone,
    input  wire logic [sifhPkg::BIN_W-1:0]   peakBin,
    output logic                             accept,
    output sifhPkg::sifhWindow               window,
    output logic                             clearBins,
    output logic                             scanStart,
    output logic                             busy,
    output logic                             resultValid,
    output sifhPkg::sifhResult               result
);

    sifhPkg::ctrlState                                    state;
    logic [$clog2(sifhPkg::SAMPLES_PER_HIS)-1:0]          sampleCnt;
    logic [sifhPkg::BIN_W-1:0]                            coarsePeak;
    logic [sifhPkg::TIME_W-1:0]                           peakBinWide;
    logic                                                 lastSample;

    // strobes during a scan are lost
    assign accept = wrEn && !busy;

    assign lastSample = (sampleCnt == (sifhPkg::SAMPLES_PER_HIS - 1));

    // peak index widened for the window arithmetic
    assign peakBinWide = {{(sifhPkg::TIME_W - sifhPkg::BIN_W){1'b0}}, peakBin};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= sifhPkg::ACQ;
            sampleCnt   <= '0;
            coarsePeak  <= '0;
            window      <= '{phase: sifhPkg::COARSE, base: '0};
            clearBins   <= 1'b0;
            scanStart   <= 1'b0;
            busy        <= 1'b0;
            resultValid <= 1'b0;
            result      <= '0;
        end else begin
            // single-cycle pulses
            clearBins   <= 1'b0;
            scanStart   <= 1'b0;
            resultValid <= 1'b0;
            case (state)
                sifhPkg::ACQ: begin
                    if (accept) begin
                        if (lastSample) begin
                            // pass complete, block further strobes
                            sampleCnt <= '0;
                            busy      <= 1'b1;
                            state     <= sifhPkg::WAIT_LAST;
                        end else begin
                            sampleCnt <= sampleCnt + 1'b1;
                        end
                    end
                end
                sifhPkg::WAIT_LAST: begin
                    // last increment lands on this edge
                    scanStart <= 1'b1;
                    state     <= sifhPkg::SCAN;
                end
                sifhPkg::SCAN: begin
                    if (peakDone) begin
                        if (window.phase == sifhPkg::COARSE) begin
                            // open the 64-unit fine window at the coarse peak
                            coarsePeak   <= peakBin;
                            window.phase <= sifhPkg::FINE;
                            window.base  <= peakBinWide << sifhPkg::WINDOW_SHIFT;
                            clearBins    <= 1'b1;
                            busy         <= 1'b0;
                            state        <= sifhPkg::ACQ;
                        end else begin
                            result.coarsePeak <= coarsePeak;
                            result.finePeak   <= peakBin;
                            // window origin plus 4 units per fine bin
                            result.peakTime   <= window.base
                                + (peakBinWide << sifhPkg::FINE_SHIFT);
                            resultValid       <= 1'b1;
                            state             <= sifhPkg::REPORT;
                        end
                    end
                end
                sifhPkg::REPORT: begin
                    // back to a fresh coarse pass
                    window    <= '{phase: sifhPkg::COARSE, base: '0};
                    clearBins <= 1'b1;
                    busy      <= 1'b0;
                    state     <= sifhPkg::ACQ;
                end
                default: begin
                    state <= sifhPkg::ACQ;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/peakDetector.sv */
`timescale 1ns/1ps
`default_nettype none

module peakDetector (
    input  wire logic                        clk,
    input  wire logic                        rstN,
    input  wire logic                        start,
    input  wire sifhPkg::binCountArray       counts,
    output logic                             peakDone,
    output logic [sifhPkg::BIN_W-1:0]        peakBin
);

    logic                            running;
    logic [sifhPkg::BIN_W-1:0]       idx;
    logic [sifhPkg::COUNT_W-1:0]     bestCount;
    logic [sifhPkg::BIN_W-1:0]       bestBin;
    logic [sifhPkg::COUNT_W-1:0]     curCount;
    logic                            takeCur;
    logic                            lastBin;

    // bin under examination this cycle
    assign curCount = counts[idx];

    // strictly larger only, so ties keep the lower index
    assign takeCur = (curCount > bestCount);

    assign lastBin = (idx == (sifhPkg::NUM_BINS - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            running   <= 1'b0;
            idx       <= '0;
            bestCount <= '0;
            bestBin   <= '0;
            peakDone  <= 1'b0;
            peakBin   <= '0;
        end else begin
            peakDone <= 1'b0;
            if (start) begin
                // restart the walk from bin 0
                running   <= 1'b1;
                idx       <= '0;
                bestCount <= '0;
                bestBin   <= '0;
            end else if (running) begin
                if (takeCur) begin
                    bestCount <= curCount;
                    bestBin   <= idx;
                end
                idx <= idx + 1'b1;
                if (lastBin) begin
                    // the last bin may still win
                    running  <= 1'b0;
                    peakDone <= 1'b1;
                    peakBin  <= takeCur ? idx : bestBin;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/binCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module binCounter (
    input  wire logic                         clk,
    input  wire logic                         rstN,
    input  wire logic                         clear,
    input  wire logic                         inc,
    output logic [sifhPkg::COUNT_W-1:0]       count
);

    logic full;

    // stop at all-ones
    assign full = &count;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (clear) begin
            // new pass, clear beats a late hit
            count <= '0;
        end else if (inc && !full) begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/timestampBinner.sv */
`timescale 1ns/1ps
`default_nettype none

module timestampBinner (
    input  wire logic                        clk,
    input  wire logic                        rstN,
    input  wire logic                        accept,
    input  wire logic [sifhPkg::TIME_W-1:0]  roughData,
    input  wire sifhPkg::sifhWindow          window,
    output sifhPkg::binHit                   hit
);

    logic [sifhPkg::TIME_W-1:0]   offset;
    logic [sifhPkg::BIN_W-1:0]    binIdx;
    logic                         inWindow;
    sifhPkg::binHit               hitNext;

    always_comb begin
        // distance from the window origin, wraps for early samples
        offset = roughData - window.base;
        if (window.phase == sifhPkg::COARSE) begin
            // coarse pass uses the top bits directly
            binIdx   = roughData[sifhPkg::TIME_W-1 -: sifhPkg::BIN_W];
            inWindow = 1'b1;
        end else begin
            // fine pass uses the offset, 4 units per bin
            binIdx   = offset[sifhPkg::FINE_SHIFT +: sifhPkg::BIN_W];
            // anything at or past 64 units (or wrapped) is outside
            inWindow = (offset[sifhPkg::TIME_W-1:sifhPkg::WINDOW_SHIFT] == '0);
        end

        hitNext.valid = accept;
        // out-of-window sample keeps valid but hits no bin
        if (accept && inWindow) begin
            hitNext.vec = {{(sifhPkg::NUM_BINS-1){1'b0}}, 1'b1} << binIdx;
        end else begin
            hitNext.vec = '0;
        end
    end

    // one register stage, counters increment on the following edge
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hit <= '0;
        end else begin
            hit <= hitNext;
        end
    end

endmodule

`default_nettype wire

/* logic/sifhPkg.sv */
`default_nettype none

package sifhPkg;

    // rough timestamp from the TDC front end
    localparam int TIME_W = 10;

    // histogram geometry
    localparam int BIN_W = 4;
    localparam int NUM_BINS = 16;

    // per-bin count, saturates at 63
    localparam int COUNT_W = 6;

    // accepted strobes that close one pass
    localparam int SAMPLES_PER_HIS = 32;

    // fine bin field starts at bit 2 of the window offset (4 units per bin)
    localparam int FINE_SHIFT = 2;

    // coarse bin index to window base (64 units per coarse bin)
    localparam int WINDOW_SHIFT = 6;

    // which histogram is being built
    typedef enum logic {
        COARSE,
        FINE
    } hisPhase;

    // controller FSM
    typedef enum logic [1:0] {
        ACQ,
        WAIT_LAST,
        SCAN,
        REPORT
    } ctrlState;

    // all bin counts side by side, bin 0 in the low slice
    typedef logic [NUM_BINS-1:0][COUNT_W-1:0] binCountArray;

    // registered binner output
    typedef struct packed {
        logic                valid;
        logic [NUM_BINS-1:0] vec;
    } binHit;

    // current pass and fine window origin
    typedef struct packed {
        hisPhase             phase;
        logic [TIME_W-1:0]   base;
    } sifhWindow;

    // reported measurement
    typedef struct packed {
        logic [BIN_W-1:0]    coarsePeak;
        logic [BIN_W-1:0]    finePeak;
        logic [TIME_W-1:0]   peakTime;
    } sifhResult;

endpackage

`default_nettype wire
